// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 64;
    localparam int word_w = 32;

    typedef logic [addr_w-1:0] bus_addr_t;
    typedef logic [data_w-1:0] bus_data_t;

    // bit 2 set means zero-extended load
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_type_e;

    // scratch ram
    localparam bus_addr_t ram_base  = 32'h0000_1000;
    localparam int        ram_words = 1024;
    localparam int        ram_idx_w = $clog2(ram_words);

    // bit 3 tells the two timer registers apart
    localparam bus_addr_t mtimecmp_addr  = 32'h0200_4000;
    localparam bus_addr_t mtime_addr     = 32'h0200_bff8;
    localparam bus_data_t mtimecmp_reset = 64'h0000_0000_8000_0000;

    // plic map
    localparam bus_addr_t plic_base           = 32'h0c00_0000;
    localparam bus_addr_t plic_pending_addr   = plic_base + 32'h0000_1000;
    localparam bus_addr_t plic_enable_addr    = plic_base + 32'h0000_2000;
    localparam bus_addr_t plic_threshold_addr = plic_base + 32'h0020_0000;
    localparam bus_addr_t plic_claim_addr     = plic_base + 32'h0020_0004;
    localparam bus_addr_t plic_ctx_stride_en  = 32'h0000_0080;
    localparam bus_addr_t plic_ctx_stride     = 32'h0000_1000;

    localparam int plic_sources = 6;
    localparam int prio_w       = 3;
    localparam int plic_src_id  = 1;   // the only wired source

endpackage

// ==== verilog/periph_bus_if.sv ====
interface periph_bus_if;
    import soc_pkg::*;

    logic      sel;
    logic      rd;     // level held until ack
    logic      wr;
    bus_addr_t addr;
    bus_data_t wdata;
    ls_type_e  ls_type;
    bus_data_t rdata;  // valid while ack is high
    logic      ack;    // one cycle

    modport target (
        input  sel, rd, wr, addr, wdata, ls_type,
        output rdata, ack
    );

    modport decoder (
        output sel, rd, wr, addr, wdata, ls_type,
        input  rdata, ack
    );

endinterface

// ==== verilog/bus_decoder.sv ====
module bus_decoder (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  soc_pkg::bus_addr_t   bus_address,
    input  soc_pkg::bus_data_t   bus_write_data,
    input  soc_pkg::ls_type_e    bus_ls_type,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    output soc_pkg::bus_data_t   bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done,
    periph_bus_if.decoder        ram_bus,
    periph_bus_if.decoder        timer_bus,
    periph_bus_if.decoder        plic_bus
);
    import soc_pkg::*;

    logic      ram_sel;
    logic      timer_sel;
    logic      prio_hit;
    logic      plic_sel;
    logic      none_sel;
    logic      unm_ack;
    logic      ack_any;
    bus_data_t rdata_mux;

    assign ram_sel   = (bus_address >= ram_base) &&
                       (bus_address < ram_base + bus_addr_t'(4 * ram_words));
    assign timer_sel = (bus_address == mtime_addr) || (bus_address == mtimecmp_addr);
    assign prio_hit  = (bus_address >= plic_base) &&
                       (bus_address < plic_base + bus_addr_t'(4 * plic_sources));
    assign plic_sel  = prio_hit
                    || (bus_address == plic_pending_addr)
                    || (bus_address == plic_enable_addr)
                    || (bus_address == plic_enable_addr + plic_ctx_stride_en)
                    || (bus_address == plic_threshold_addr)
                    || (bus_address == plic_threshold_addr + plic_ctx_stride)
                    || (bus_address == plic_claim_addr)
                    || (bus_address == plic_claim_addr + plic_ctx_stride);
    assign none_sel  = !(ram_sel || timer_sel || plic_sel);

    // every peer sees the same request and only sel tells them apart
    assign ram_bus.sel       = ram_sel;
    assign ram_bus.rd        = ram_sel && !bus_read_done;
    assign ram_bus.wr        = ram_sel && !bus_write_done;
    assign ram_bus.addr      = bus_address;
    assign ram_bus.wdata     = bus_write_data;
    assign ram_bus.ls_type   = bus_ls_type;

    assign timer_bus.sel     = timer_sel;
    assign timer_bus.rd      = timer_sel && !bus_read_done;
    assign timer_bus.wr      = timer_sel && !bus_write_done;
    assign timer_bus.addr    = bus_address;
    assign timer_bus.wdata   = bus_write_data;
    assign timer_bus.ls_type = bus_ls_type;

    assign plic_bus.sel      = plic_sel;
    assign plic_bus.rd       = plic_sel && !bus_read_done;
    assign plic_bus.wr       = plic_sel && !bus_write_done;
    assign plic_bus.addr     = bus_address;
    assign plic_bus.wdata    = bus_write_data;
    assign plic_bus.ls_type  = bus_ls_type;

    assign ack_any = ram_bus.ack || timer_bus.ack || plic_bus.ack || unm_ack;

    always_comb begin
        if (ram_sel)
            rdata_mux = ram_bus.rdata;
        else if (timer_sel)
            rdata_mux = timer_bus.rdata;
        else if (plic_sel)
            rdata_mux = plic_bus.rdata;
        else
            rdata_mux = '0;   // unmapped reads back zero
    end

    // unmapped responder answers one cycle after done drops
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            unm_ack <= 1'b0;
        end else begin
            unm_ack <= none_sel && !(bus_read_done && bus_write_done) && !unm_ack;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            if (ack_any) begin
                if (!bus_read_done) begin
                    bus_read_done <= 1'b1;
                    bus_read_data <= rdata_mux;
                end
                if (!bus_write_done)
                    bus_write_done <= 1'b1;
            end
            if (bus_read_enable && bus_read_done)
                bus_read_done <= 1'b0;    // ignored while busy
            if (bus_write_enable && bus_write_done)
                bus_write_done <= 1'b0;
        end
    end

endmodule

// ==== verilog/scratch_ram.sv ====
module scratch_ram (
    input logic          CLOCK_50,
    input logic          KEY0,
    periph_bus_if.target bus
);
    import soc_pkg::*;

    logic [word_w-1:0]    mem [ram_words];
    logic [addr_w-1:0]    rel_addr;
    logic [ram_idx_w-1:0] idx;
    logic [ram_idx_w-1:0] nxt_idx;
    logic [1:0]           off;
    logic [word_w-1:0]    word_lo;
    logic [word_w-1:0]    word_hi;
    logic [word_w-1:0]    shifted;
    bus_data_t            load_val;
    logic                 active;
    logic                 step;     // second word of ld/sd

    assign active   = bus.sel && (bus.rd || bus.wr) && !bus.ack;
    assign rel_addr = bus.addr - ram_base;
    assign idx      = rel_addr[ram_idx_w+1:2];
    assign nxt_idx  = idx + 1'b1;
    assign off      = bus.addr[1:0];
    assign word_lo  = mem[idx];
    assign word_hi  = mem[nxt_idx];
    assign shifted  = word_lo >> {off, 3'b000};

    always_comb begin
        case (bus.ls_type)
            ls_b:    load_val = {{(data_w-8){shifted[7]}}, shifted[7:0]};
            ls_h:    load_val = {{(data_w-16){shifted[15]}}, shifted[15:0]};
            ls_w:    load_val = {{(data_w-word_w){shifted[word_w-1]}}, shifted};
            ls_bu:   load_val = {{(data_w-8){1'b0}}, shifted[7:0]};
            ls_hu:   load_val = {{(data_w-16){1'b0}}, shifted[15:0]};
            ls_wu:   load_val = {{(data_w-word_w){1'b0}}, shifted};
            default: load_val = '0;   // ld goes through the step path
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus.ack <= 1'b0;
            step    <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            if (active) begin
                if (bus.ls_type == ls_d && !step) begin
                    step <= 1'b1;
                end else begin
                    step    <= 1'b0;
                    bus.ack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (active && bus.rd) begin
            if (bus.ls_type == ls_d) begin
                if (!step)
                    bus.rdata[word_w-1:0] <= word_lo;
                else
                    bus.rdata[data_w-1:word_w] <= word_hi;
            end else begin
                bus.rdata <= load_val;
            end
        end
    end

    // store lanes
    always_ff @(posedge CLOCK_50) begin
        if (active && bus.wr) begin
            case (bus.ls_type)
                ls_b: mem[idx][{off, 3'b000} +: 8]   <= bus.wdata[7:0];
                ls_h: mem[idx][{off[1], 4'b0000} +: 16] <= bus.wdata[15:0];
                ls_w: mem[idx] <= bus.wdata[word_w-1:0];
                ls_d: begin
                    if (!step)
                        mem[idx] <= bus.wdata[word_w-1:0];
                    else
                        mem[nxt_idx] <= bus.wdata[data_w-1:word_w];
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== verilog/plic.sv ====
module plic (
    input  logic         CLOCK_50,
    input  logic         KEY0,
    periph_bus_if.target bus,
    input  logic         irq_source,
    output logic         meip_interrupt,
    output logic         msip_interrupt
);
    import soc_pkg::*;

    typedef enum logic [2:0] {
        reg_prio,
        reg_pending,
        reg_enable,
        reg_threshold,
        reg_claim
    } plic_reg_e;

    logic [prio_w-1:0] prio_reg      [plic_sources];
    logic [word_w-1:0] enable_reg    [2];
    logic [prio_w-1:0] threshold_reg [2];
    logic [word_w-1:0] claim_id      [2];
    logic [word_w-1:0] pending_word;
    logic              src_pending;
    logic              irq_q;
    plic_reg_e         reg_sel;
    logic              ctx;
    logic [2:0]        prio_id;
    logic              active;
    logic              claim_take;

    assign active  = bus.sel && (bus.rd || bus.wr) && !bus.ack;
    assign prio_id = bus.addr[4:2];
    assign ctx     = bus.addr[21] ? bus.addr[12] : bus.addr[7];  // context select

    // register kind from the offset bits as the decoder checks the full address
    always_comb begin
        if (bus.addr[21])
            reg_sel = bus.addr[2] ? reg_claim : reg_threshold;
        else if (bus.addr[13])
            reg_sel = reg_enable;
        else if (bus.addr[12])
            reg_sel = reg_pending;
        else
            reg_sel = reg_prio;
    end

    assign pending_word = word_w'(src_pending) << plic_src_id;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = (src_pending && enable_reg[c][plic_src_id]) ? word_w'(plic_src_id) : '0;
        end
    end

    assign meip_interrupt = (claim_id[0] != '0);
    assign msip_interrupt = (claim_id[1] != '0);
    assign claim_take     = active && bus.rd && (reg_sel == reg_claim) && (claim_id[ctx] != '0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus.ack     <= 1'b0;
            irq_q       <= 1'b0;
            src_pending <= 1'b0;
            for (int i = 0; i < plic_sources; i++)
                prio_reg[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable_reg[c]    <= '0;
                threshold_reg[c] <= '0;
            end
        end else begin
            bus.ack <= active;
            irq_q   <= irq_source;
            if (irq_source && !irq_q)
                src_pending <= 1'b1;    // fresh edge beats the claim
            else if (claim_take)
                src_pending <= 1'b0;
            if (active && bus.wr) begin
                case (reg_sel)
                    reg_prio:      prio_reg[prio_id]  <= bus.wdata[prio_w-1:0];
                    reg_enable:    enable_reg[ctx]    <= bus.wdata[word_w-1:0];
                    reg_threshold: threshold_reg[ctx] <= bus.wdata[prio_w-1:0];
                    default: ;  // pending is read only and claim writes do nothing
                endcase
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (active && bus.rd) begin
            case (reg_sel)
                reg_prio:      bus.rdata <= bus_data_t'(prio_reg[prio_id]);
                reg_pending:   bus.rdata <= bus_data_t'(pending_word);
                reg_enable:    bus.rdata <= bus_data_t'(enable_reg[ctx]);
                reg_threshold: bus.rdata <= bus_data_t'(threshold_reg[ctx]);
                reg_claim:     bus.rdata <= bus_data_t'(claim_id[ctx]);
                default:       bus.rdata <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/machine_timer.sv ====
module machine_timer (
    input logic          CLOCK_50,
    input logic          KEY0,
    periph_bus_if.target bus
);
    import soc_pkg::*;

    bus_data_t mtime;
    bus_data_t mtimecmp;
    logic      active;

    assign active = bus.sel && (bus.rd || bus.wr) && !bus.ack;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus.ack  <= 1'b0;
            mtime    <= '0;
            mtimecmp <= mtimecmp_reset;
        end else begin
            bus.ack <= active;
            mtime   <= mtime + 1'b1;   // free running
            // writes to mtime (addr bit 3 high) are dropped
            if (active && bus.wr && !bus.addr[3])
                mtimecmp <= bus.wdata;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (active && bus.rd)
            bus.rdata <= bus.addr[3] ? mtime : mtimecmp;
    end

endmodule

// ==== verilog/soc_bus.sv ====
module soc_bus (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  soc_pkg::bus_addr_t bus_address,
    input  soc_pkg::bus_data_t bus_write_data,
    input  soc_pkg::ls_type_e  bus_ls_type,
    input  logic               bus_read_enable,
    input  logic               bus_write_enable,
    output soc_pkg::bus_data_t bus_read_data,
    output logic               bus_read_done,
    output logic               bus_write_done,
    input  logic               irq_source,
    output logic               meip_interrupt,
    output logic               msip_interrupt
);

    periph_bus_if ram_bus ();
    periph_bus_if timer_bus ();
    periph_bus_if plic_bus ();

    // single master, so the decoder owns the handshake
    bus_decoder u_decoder (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_bus          (ram_bus),
        .timer_bus        (timer_bus),
        .plic_bus         (plic_bus)
    );

    scratch_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus)
    );

    machine_timer u_timer (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (timer_bus)
    );

    plic u_plic (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus            (plic_bus),
        .irq_source     (irq_source),       // former uart irq line
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

// ==== tests/tb_soc_bus.sv ====
module tb_soc_bus;
    import soc_pkg::*;

    logic      CLOCK_50 = 1'b0;
    logic      KEY0 = 1'b0;
    bus_addr_t bus_address = '0;
    bus_data_t bus_write_data = '0;
    ls_type_e  bus_ls_type = ls_w;
    logic      bus_read_enable = 1'b0;
    logic      bus_write_enable = 1'b0;
    bus_data_t bus_read_data;
    logic      bus_read_done;
    logic      bus_write_done;
    logic      irq_source = 1'b0;
    logic      meip_interrupt;
    logic      msip_interrupt;

    int          mismatch_errors = 0;
    int          timing_errors = 0;
    int          other_errors = 0;
    int          expect_cycles = 2;     // latency of the access being issued
    int          read_low = 0;
    int          read_expect = 0;
    int          write_low = 0;
    int          write_expect = 0;
    logic [31:0] lcg_state = 32'd89;
    logic [7:0]  ram_model [4096];      // byte image of the scratch ram

    soc_bus uut (.*);

    always #5 CLOCK_50 = ~CLOCK_50;

    // at most one done flag low at any time
    one_access_in_flight: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done || bus_write_done)
    else begin
        other_errors++;
        $display("both done flags low at %0t, two accesses in flight", $time);
    end

    // cycles that each done flag stays low
    always @(posedge CLOCK_50) begin
        if (!KEY0) begin
            read_low = 0;
        end else if (!bus_read_done) begin
            if (read_low == 0)
                read_expect = expect_cycles;
            read_low++;
        end else if (read_low != 0) begin
            assert (read_low == read_expect) else begin
                timing_errors++;
                $display("Mismatch at %0t: bus_read_done low cycles expected %0d, actual %0d",
                         $time, read_expect, read_low);
            end
            read_low = 0;
        end
    end

    always @(posedge CLOCK_50) begin
        if (!KEY0) begin
            write_low = 0;
        end else if (!bus_write_done) begin
            if (write_low == 0)
                write_expect = expect_cycles;
            write_low++;
        end else if (write_low != 0) begin
            assert (write_low == write_expect) else begin
                timing_errors++;
                $display("Mismatch at %0t: bus_write_done low cycles expected %0d, actual %0d",
                         $time, write_expect, write_low);
            end
            write_low = 0;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int random_below(int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[30:16]) % n;   // low lcg bits have short periods
    endfunction

    // ld and sd to the ram take one extra step
    function automatic int expected_latency(bus_addr_t addr, ls_type_e t);
        if (t == ls_d && addr >= ram_base && addr < ram_base + 32'h1000)
            return 3;
        return 2;
    endfunction

    function automatic bus_data_t expected_load(int rel, ls_type_e t);
        logic [31:0] raw;
        raw = {ram_model[rel+3], ram_model[rel+2], ram_model[rel+1], ram_model[rel]};
        case (t)
            ls_b:    return {{56{raw[7]}}, raw[7:0]};
            ls_h:    return {{48{raw[15]}}, raw[15:0]};
            ls_w:    return {{32{raw[31]}}, raw};
            ls_bu:   return {56'h0, raw[7:0]};
            ls_hu:   return {48'h0, raw[15:0]};
            default: return {32'h0, raw};
        endcase
    endfunction

    task automatic store_model(int rel, logic [31:0] v, int n);
        for (int k = 0; k < n; k++)
            ram_model[rel+k] = v[8*k +: 8];
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatch, %0d timing, %0d other",
                 mismatch_errors, timing_errors, other_errors);
        if (mismatch_errors + timing_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic check_value(string name, bus_data_t expected, bus_data_t actual);
        assert (actual === expected) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // called 1 unit after a rising edge
    task automatic bus_read(bus_addr_t addr, ls_type_e t, output bus_data_t data);
        int n;
        bus_address     = addr;
        bus_ls_type     = t;
        expect_cycles   = expected_latency(addr, t);
        bus_read_enable = 1'b1;
        @(posedge CLOCK_50);
        #1;
        bus_read_enable = 1'b0;
        assert (!bus_read_done) else begin
            other_errors++;
            $display("read of %h at %0t was not accepted", addr, $time);
        end
        n = 0;
        while (!bus_read_done && n < 50) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!bus_read_done) begin
            other_errors++;
            $display("timeout at %0t: read of %h never completed", $time, addr);
            finish_run();
        end else begin
            data = bus_read_data;
        end
    endtask

    task automatic bus_write(bus_addr_t addr, ls_type_e t, bus_data_t data);
        int n;
        bus_address      = addr;
        bus_ls_type      = t;
        bus_write_data   = data;
        expect_cycles    = expected_latency(addr, t);
        bus_write_enable = 1'b1;
        @(posedge CLOCK_50);
        #1;
        bus_write_enable = 1'b0;
        assert (!bus_write_done) else begin
            other_errors++;
            $display("write of %h at %0t was not accepted", addr, $time);
        end
        n = 0;
        while (!bus_write_done && n < 50) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!bus_write_done) begin
            other_errors++;
            $display("timeout at %0t: write of %h never completed", $time, addr);
            finish_run();
        end
    endtask

    task automatic check_load(int rel, ls_type_e t);
        bus_data_t d;
        bus_read(ram_base + bus_addr_t'(rel), t, d);
        check_value($sformatf("bus_read_data %s", t.name()), expected_load(rel, t), d);
    endtask

    task automatic pulse_irq_and_wait();
        int n;
        irq_source = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_source = 1'b0;
        n = 0;
        while (!meip_interrupt && n < 20) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!meip_interrupt) begin
            other_errors++;
            $display("timeout at %0t: meip_interrupt never rose", $time);
            finish_run();
        end
    endtask

    task automatic ram_narrow_pass();
        int          rel;
        int          off;
        logic [31:0] r;
        rel = random_below(64) * 4;
        r = next_random();
        bus_write(ram_base + bus_addr_t'(rel), ls_w, {32'h0, r});
        store_model(rel, r, 4);
        off = random_below(4);
        r = next_random();
        bus_write(ram_base + bus_addr_t'(rel + off), ls_b, {32'h0, r});
        store_model(rel + off, r, 1);
        off = random_below(2) * 2;
        r = next_random();
        bus_write(ram_base + bus_addr_t'(rel + off), ls_h, {32'h0, r});
        store_model(rel + off, r, 2);
        off = random_below(4);
        check_load(rel + off, ls_b);
        check_load(rel + off, ls_bu);
        off = random_below(2) * 2;
        check_load(rel + off, ls_h);
        check_load(rel + off, ls_hu);
        check_load(rel, ls_w);
        check_load(rel, ls_wu);
    endtask

    initial begin
        bus_data_t   d;
        bus_data_t   t0;
        logic [31:0] lo;
        logic [31:0] hi;
        repeat (5) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        assert (bus_read_done && bus_write_done && !meip_interrupt && !msip_interrupt)
        else begin
            other_errors++;
            $display("state after reset is wrong at %0t", $time);
        end

        bus_read(mtimecmp_addr, ls_d, d);
        check_value("mtimecmp", 64'h8000_0000, d);
        bus_read(32'h0000_0010, ls_w, d);   // below the ram
        check_value("unmapped read", 64'h0, d);
        bus_write(32'h0000_0010, ls_w, 64'h1234);

        for (int i = 0; i < 8; i++)
            ram_narrow_pass();

        lo = next_random();
        hi = next_random();
        bus_write(ram_base + 32'h200, ls_d, {hi, lo});
        bus_read(ram_base + 32'h200, ls_d, d);
        check_value("ld data", {hi, lo}, d);
        bus_read(ram_base + 32'h204, ls_w, d);
        check_value("lw upper half", {{32{hi[31]}}, hi}, d);

        lo = next_random();
        hi = next_random();
        bus_write(mtimecmp_addr, ls_d, {hi, lo});
        bus_read(mtimecmp_addr, ls_d, d);
        check_value("mtimecmp", {hi, lo}, d);
        bus_read(mtime_addr, ls_d, t0);
        bus_read(mtime_addr, ls_d, d);
        assert (d > t0) else begin
            other_errors++;
            $display("mtime did not increase: first %h, second %h", t0, d);
        end

        for (int i = 0; i < plic_sources; i++) begin
            lo = next_random();
            bus_write(plic_base + bus_addr_t'(4 * i), ls_w, {32'h0, lo});
            bus_read(plic_base + bus_addr_t'(4 * i), ls_w, d);
            check_value($sformatf("priority %0d", i), {61'h0, lo[2:0]}, d);
        end
        for (int c = 0; c < 2; c++) begin
            lo = next_random();
            bus_write(plic_enable_addr + bus_addr_t'(c * 32'h80), ls_w, {32'h0, lo});
            bus_read(plic_enable_addr + bus_addr_t'(c * 32'h80), ls_w, d);
            check_value($sformatf("enable ctx %0d", c), {32'h0, lo}, d);
            lo = next_random();
            bus_write(plic_threshold_addr + bus_addr_t'(c * 32'h1000), ls_w, {32'h0, lo});
            bus_read(plic_threshold_addr + bus_addr_t'(c * 32'h1000), ls_w, d);
            check_value($sformatf("threshold ctx %0d", c), {61'h0, lo[2:0]}, d);
        end

        // only context 0 takes source 1
        bus_write(plic_enable_addr, ls_w, 64'h2);
        bus_write(plic_enable_addr + 32'h80, ls_w, 64'h0);
        pulse_irq_and_wait();
        check_value("msip_interrupt", 64'h0, {63'h0, msip_interrupt});
        bus_read(plic_pending_addr, ls_w, d);
        check_value("pending", 64'h2, d);
        bus_read(plic_claim_addr, ls_w, d);
        check_value("claim ctx 0", 64'h1, d);
        check_value("meip_interrupt", 64'h0, {63'h0, meip_interrupt});
        bus_read(plic_claim_addr, ls_w, d);
        check_value("second claim ctx 0", 64'h0, d);

        bus_write(plic_enable_addr + 32'h80, ls_w, 64'h2);
        pulse_irq_and_wait();
        check_value("msip_interrupt", 64'h1, {63'h0, msip_interrupt});

        repeat (3) @(posedge CLOCK_50);
        finish_run();
    end

endmodule

// ==== soc_bus.f ====
verilog/soc_pkg.sv
verilog/periph_bus_if.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/plic.sv
verilog/machine_timer.sv
verilog/soc_bus.sv
tests/tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_soc_bus -f soc_bus.f -o tb_soc_bus
./obj_dir/tb_soc_bus | tee sim.log

# exit status follows the pass line in the log
grep -q "TESTBENCH PASSED" sim.log
